// ==== design/raster_if.sv ====
// Beam position and timing flags from raster timing to the register bank and video output
`timescale 1ns/1ps

interface raster_if;

    vic_pkg::pos_t xc;          // Dot within line
    vic_pkg::pos_t rc;          // Line within frame
    logic          line_start;  // xc is 0
    logic          hsync;
    logic          vsync;
    logic          hblank;
    logic          vblank;
    logic          window;      // Display window, den already applied

    modport source (
        output xc, rc, line_start,
        output hsync, vsync, hblank, vblank, window
    );

    modport sink (
        input xc, rc, line_start,
        input hsync, vsync, hblank, vblank, window
    );

endinterface

// ==== design/raster_timing.sv ====
// Dot and line counters with registered set/clear decodes for sync, blank and display window
`timescale 1ns/1ps
`include "vic_defines.svh"

module raster_timing (
    input  logic     dot_clk,
    input  logic     reset,
    vic_cfg_if.sink  cfg,
    raster_if.source ras
);

    localparam vic_pkg::pos_t XC_LAST  = vic_pkg::pos_t'(`VIC_DOTS_PER_LINE - 1);
    localparam vic_pkg::pos_t RC_LAST  = vic_pkg::pos_t'(`VIC_LINES_PER_FRAME - 1);
    localparam vic_pkg::pos_t DEN_LINE = vic_pkg::pos_t'(`VIC_DEN_LINE);

    vic_pkg::pos_t xc;
    vic_pkg::pos_t rc;
    logic          hsync;
    logic          vsync;
    logic          hblank;
    logic          vblank;
    logic          col40;         // Horizontal window, 40 columns
    logic          col38;         // Horizontal window, 38 columns
    logic          row25;         // Vertical window, 25 rows
    logic          row24;         // Vertical window, 24 rows
    logic          den_latched;   // DEN as seen on the sample line

    // Next value of a flag that sets at one position and clears at another
    function automatic logic decode(input logic cur, input vic_pkg::pos_t pos,
                                    input vic_pkg::pos_t set_pos,
                                    input vic_pkg::pos_t clr_pos);
        logic nxt;
        nxt = cur;
        if (pos == set_pos)
            nxt = 1'b1;
        else if (pos == clr_pos)
            nxt = 1'b0;
        return nxt;
    endfunction

    // Beam counters, advance every clock
    always_ff @(posedge dot_clk) begin
        if (reset) begin
            xc <= '0;
            rc <= '0;
        end else if (xc == XC_LAST) begin
            xc <= '0;
            rc <= (rc == RC_LAST) ? '0 : rc + 1'b1;   // PAL frame wrap
        end else begin
            xc <= xc + 1'b1;
        end
    end

    // Flags lag the counters by one clock
    always_ff @(posedge dot_clk) begin
        if (reset) begin
            hsync       <= 1'b0;
            hblank      <= 1'b0;
            col40       <= 1'b0;
            col38       <= 1'b0;
            vsync       <= 1'b0;
            vblank      <= 1'b0;
            row25       <= 1'b0;
            row24       <= 1'b0;
            den_latched <= 1'b0;
        end else begin
            // Horizontal, on dot count
            hsync  <= decode(hsync, xc, vic_pkg::pos_t'(`VIC_HSYNC_SET),
                             vic_pkg::pos_t'(`VIC_HSYNC_CLR));
            hblank <= decode(hblank, xc, vic_pkg::pos_t'(`VIC_HBLANK_SET),
                             vic_pkg::pos_t'(`VIC_HBLANK_CLR));
            col40  <= decode(col40, xc, vic_pkg::pos_t'(`VIC_COL40_SET),
                             vic_pkg::pos_t'(`VIC_COL40_CLR));
            col38  <= decode(col38, xc, vic_pkg::pos_t'(`VIC_COL38_SET),
                             vic_pkg::pos_t'(`VIC_COL38_CLR));
            // Vertical, on line count
            vsync  <= decode(vsync, rc, vic_pkg::pos_t'(`VIC_VSYNC_SET),
                             vic_pkg::pos_t'(`VIC_VSYNC_CLR));
            vblank <= decode(vblank, rc, vic_pkg::pos_t'(`VIC_VBLANK_SET),
                             vic_pkg::pos_t'(`VIC_VBLANK_CLR));
            row25  <= decode(row25, rc, vic_pkg::pos_t'(`VIC_ROW25_SET),
                             vic_pkg::pos_t'(`VIC_ROW25_CLR));
            row24  <= decode(row24, rc, vic_pkg::pos_t'(`VIC_ROW24_SET),
                             vic_pkg::pos_t'(`VIC_ROW24_CLR));
            if (rc == DEN_LINE)
                den_latched <= cfg.den;    // Held for the rest of the frame
        end
    end

    assign ras.xc         = xc;
    assign ras.rc         = rc;
    assign ras.line_start = (xc == '0);
    assign ras.hsync      = hsync;
    assign ras.vsync      = vsync;
    assign ras.hblank     = hblank;
    assign ras.vblank     = vblank;
    // Column and row size picked by CSEL and RSEL
    assign ras.window     = (cfg.csel ? col40 : col38) & (cfg.rsel ? row25 : row24) & den_latched;

endmodule

// ==== design/vic_cfg_if.sv ====
// Register bank settings for raster timing and video output; driven through regs, read through sink
`timescale 1ns/1ps

interface vic_cfg_if;

    logic              den;           // Display enable
    logic              rsel;          // 25 rows when set
    logic              csel;          // 40 columns when set
    vic_pkg::pos_t     raster_watch;  // Interrupt compare line
    vic_pkg::color_t   border_color;
    vic_pkg::color_t   bg_color;

    modport regs (
        output den, rsel, csel, raster_watch,
        output border_color, bg_color
    );

    modport sink (
        input den, rsel, csel, raster_watch,
        input border_color, bg_color
    );

endinterface

// ==== design/vic_pkg.sv ====
// Shared register address enum and data types, referenced by scoped name from RTL and testbench
`include "vic_defines.svh"

package vic_pkg;

    // Register addresses kept from the full chip
    typedef enum logic [`VIC_ADDR_W-1:0] {
        CTRL1        = 6'h11,   // Raster bit 8, DEN, RSEL
        RASTER       = 6'h12,   // Compare line low byte, reads beam line
        CTRL2        = 6'h16,   // CSEL in bit 3
        IRQ_STATUS   = 6'h19,   // Write 1 to bit 0 to clear
        IRQ_ENABLE   = 6'h1A,
        BORDER_COLOR = 6'h20,
        BG0_COLOR    = 6'h21
    } reg_addr_e;

    // Colour index into the 16 entry palette
    typedef logic [`VIC_COLOR_W-1:0] color_t;

    // Beam position, dots or lines
    typedef logic [`VIC_POS_W-1:0] pos_t;

    // CPU register data
    typedef logic [`VIC_DATA_W-1:0] cpu_data_t;

endpackage

// ==== design/vic_regs.sv ====
// CPU side register bank with chip-select access and the latched raster compare interrupt
`timescale 1ns/1ps
`include "vic_defines.svh"

module vic_regs (
    input  logic               dot_clk,
    input  logic               reset,
    input  logic               cs,
    input  logic               we,
    input  vic_pkg::reg_addr_e addr,
    input  vic_pkg::cpu_data_t wdata,
    output vic_pkg::cpu_data_t rdata,
    output logic               irq,
    vic_cfg_if.regs            cfg,
    raster_if.sink             ras
);

    vic_pkg::cpu_data_t ctrl1;         // Bit 7 is compare line bit 8
    vic_pkg::cpu_data_t raster_lo;     // Compare line low byte
    logic [5:0]         ctrl2;         // Upper two bits not stored
    logic               irq_en;
    logic               irq_latch;
    vic_pkg::color_t    border_color;
    vic_pkg::color_t    bg_color;
    vic_pkg::pos_t      raster_watch;
    logic               wr_en;
    logic               rd_en;
    logic               raster_hit;

    assign wr_en        = cs & we;
    assign rd_en        = cs & ~we;
    assign raster_watch = {ctrl1[7], raster_lo};
    assign raster_hit   = ras.line_start && (ras.rc == raster_watch);  // Once per line, at dot 0

    // CPU writes; IRQ_STATUS is handled with the latch
    always_ff @(posedge dot_clk) begin
        if (reset) begin
            ctrl1        <= '0;
            raster_lo    <= '0;
            ctrl2        <= '0;
            irq_en       <= 1'b0;
            border_color <= '0;
            bg_color     <= '0;
        end else if (wr_en) begin
            case (addr)
                vic_pkg::CTRL1:        ctrl1        <= wdata;
                vic_pkg::RASTER:       raster_lo    <= wdata;
                vic_pkg::CTRL2:        ctrl2        <= wdata[5:0];
                vic_pkg::IRQ_ENABLE:   irq_en       <= wdata[0];
                vic_pkg::BORDER_COLOR: border_color <= wdata[3:0];
                vic_pkg::BG0_COLOR:    bg_color     <= wdata[3:0];
                default:               ;            // No storage behind other addresses
            endcase
        end
    end

    // Raster latch; a new compare hit wins over a same-edge clear
    always_ff @(posedge dot_clk) begin
        if (reset)
            irq_latch <= 1'b0;
        else if (raster_hit)
            irq_latch <= 1'b1;
        else if (wr_en && (addr == vic_pkg::IRQ_STATUS) && wdata[0])
            irq_latch <= 1'b0;               // Write 1 to clear
    end

    assign irq = irq_latch & irq_en;

    // Registered read, zero on any clock without a read
    always_ff @(posedge dot_clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (rd_en) begin
            case (addr)
                vic_pkg::CTRL1:        rdata <= {ras.rc[`VIC_POS_W-1], ctrl1[6:0]};
                vic_pkg::RASTER:       rdata <= ras.rc[7:0];     // Live beam line
                vic_pkg::CTRL2:        rdata <= {2'b11, ctrl2};
                vic_pkg::IRQ_STATUS:   rdata <= {irq, 6'b111111, irq_latch};
                vic_pkg::IRQ_ENABLE:   rdata <= {7'b1111111, irq_en};
                vic_pkg::BORDER_COLOR: rdata <= {4'b1111, border_color};
                vic_pkg::BG0_COLOR:    rdata <= {4'b1111, bg_color};
                default:               rdata <= 8'hFF;           // Unimplemented
            endcase
        end else begin
            rdata <= '0;
        end
    end

    // Settings out to timing and video
    assign cfg.den          = ctrl1[4];
    assign cfg.rsel         = ctrl1[3];
    assign cfg.csel         = ctrl2[3];
    assign cfg.raster_watch = raster_watch;
    assign cfg.border_color = border_color;
    assign cfg.bg_color     = bg_color;

endmodule

// ==== design/vic_top.sv ====
// Top level of the raster side; plain CPU bus and video pins around regs, timing and video output
`timescale 1ns/1ps
`include "vic_defines.svh"

module vic_top (
    input  logic                   dot_clk,
    input  logic                   reset,
    input  logic                   cs,
    input  logic                   we,
    input  logic [`VIC_ADDR_W-1:0] addr,
    input  vic_pkg::cpu_data_t     wdata,
    output vic_pkg::cpu_data_t     rdata,
    output logic                   irq,
    output vic_pkg::color_t        color,
    output logic                   sync,
    output logic                   blank
);

    vic_cfg_if i_cfg ();   // Register settings
    raster_if  i_ras ();   // Beam position and flags

    vic_regs i_regs (
        .dot_clk (dot_clk),
        .reset   (reset),
        .cs      (cs),
        .we      (we),
        .addr    (vic_pkg::reg_addr_e'(addr)),
        .wdata   (wdata),
        .rdata   (rdata),
        .irq     (irq),
        .cfg     (i_cfg.regs),
        .ras     (i_ras.sink)
    );

    raster_timing i_timing (
        .dot_clk (dot_clk),
        .reset   (reset),
        .cfg     (i_cfg.sink),
        .ras     (i_ras.source)
    );

    video_out i_video (
        .dot_clk (dot_clk),
        .reset   (reset),
        .cfg     (i_cfg.sink),
        .ras     (i_ras.sink),
        .color   (color),
        .sync    (sync),
        .blank   (blank)
    );

endmodule

// ==== design/video_out.sv ====
// Final video stage; registers border or background colour, composite sync and blank
`timescale 1ns/1ps

module video_out (
    input  logic            dot_clk,
    input  logic            reset,
    vic_cfg_if.sink         cfg,
    raster_if.sink          ras,
    output vic_pkg::color_t color,
    output logic            sync,
    output logic            blank
);

    logic            any_blank;
    vic_pkg::color_t color_nxt;

    assign any_blank = ras.hblank | ras.vblank;

    // Black while blanked, background inside the window, border elsewhere
    always_comb begin
        if (any_blank)
            color_nxt = '0;
        else if (ras.window)
            color_nxt = cfg.bg_color;
        else
            color_nxt = cfg.border_color;
    end

    // One more stage after the timing flags
    always_ff @(posedge dot_clk) begin
        if (reset) begin
            color <= '0;
            sync  <= 1'b0;
            blank <= 1'b0;
        end else begin
            color <= color_nxt;
            sync  <= ras.hsync ^ ras.vsync;   // Inverted line sync during vsync
            blank <= any_blank;
        end
    end

endmodule

// ==== include/vic_defines.svh ====
// Raster geometry, decode positions and bus widths; included by the package, RTL and testbench
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// PAL raster size
`define VIC_DOTS_PER_LINE   504   // Dot counter wraps after 503
`define VIC_LINES_PER_FRAME 312   // Line counter wraps after 311

// Widths
`define VIC_POS_W   9             // Dot and line counters
`define VIC_ADDR_W  6             // CPU register address
`define VIC_DATA_W  8             // CPU register data
`define VIC_COLOR_W 4             // Colour index

// Decodes are active from SET up to CLR minus 1
`define VIC_HSYNC_SET  400
`define VIC_HSYNC_CLR  436
`define VIC_HBLANK_SET 380
`define VIC_HBLANK_CLR 480
`define VIC_VSYNC_SET  296
`define VIC_VSYNC_CLR  300
`define VIC_VBLANK_SET 292
`define VIC_VBLANK_CLR 304
`define VIC_COL40_SET  19         // 40 column window
`define VIC_COL40_CLR  339
`define VIC_COL38_SET  26         // 38 column window
`define VIC_COL38_CLR  330
`define VIC_ROW25_SET  51         // 25 row window
`define VIC_ROW25_CLR  251
`define VIC_ROW24_SET  55         // 24 row window
`define VIC_ROW24_CLR  247

`define VIC_DEN_LINE      48      // Display enable sampled on this line only
`define VIC_VIDEO_LATENCY 2       // Beam position to video pins, in clocks

`endif

// ==== sim.f ====
+incdir+include
design/vic_pkg.sv
design/vic_cfg_if.sv
design/raster_if.sv
design/vic_regs.sv
design/raster_timing.sv
design/video_out.sv
design/vic_top.sv
verification/tb_vic.sv

// ==== verification/tb_vic.sv ====
// Testbench for vic_top; drives the CPU bus, models the raster and compares video, bus and irq
`timescale 1ns/1ps
`include "vic_defines.svh"

module tb_vic;

    localparam longint FRAME = `VIC_DOTS_PER_LINE * `VIC_LINES_PER_FRAME;
    // Four checked frames, up to three for the interrupt, one spare
    localparam longint WATCHDOG_NS = 8 * FRAME * 10;

    logic               dot_clk;
    logic               reset;
    logic               cs;
    logic               we;
    logic [5:0]         addr;
    vic_pkg::cpu_data_t wdata;
    vic_pkg::cpu_data_t rdata;
    logic               irq;
    vic_pkg::color_t    color;
    logic               sync;
    logic               blank;

    longint             cycle;         // Clocks since reset release
    longint             last_write;    // Cycle of the latest register write
    int                 errors;
    int                 checks;
    logic               read_last;     // Read accepted at the previous edge
    logic [31:0]        lcg_state;
    logic               den_sh;        // Register shadows for the model
    logic               rsel_sh;
    logic               csel_sh;
    vic_pkg::color_t    border_sh;
    vic_pkg::color_t    bg_sh;

    vic_top i_dut (
        .dot_clk (dot_clk),
        .reset   (reset),
        .cs      (cs),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .irq     (irq),
        .color   (color),
        .sync    (sync),
        .blank   (blank)
    );

    initial begin
        dot_clk = 1'b0;
        forever #5 dot_clk = ~dot_clk;   // 10 ns period
    end

    // Random byte from an LCG
    function automatic vic_pkg::cpu_data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[30:23];   // Upper bits spread better
    endfunction

    // Beam position p clocks after reset release
    // Result is {xc, rc, color, sync, blank}
    function automatic logic [23:0] raster_model(input longint p);
        int              xc;
        int              rc;
        logic            hs;
        logic            vs;
        logic            hb;
        logic            vb;
        logic            in_col;
        logic            in_row;
        vic_pkg::color_t c;
        xc = int'(p % `VIC_DOTS_PER_LINE);
        rc = int'((p / `VIC_DOTS_PER_LINE) % `VIC_LINES_PER_FRAME);
        hs = (xc >= `VIC_HSYNC_SET) && (xc < `VIC_HSYNC_CLR);
        hb = (xc >= `VIC_HBLANK_SET) && (xc < `VIC_HBLANK_CLR);
        vs = (rc >= `VIC_VSYNC_SET) && (rc < `VIC_VSYNC_CLR);
        vb = (rc >= `VIC_VBLANK_SET) && (rc < `VIC_VBLANK_CLR);
        in_col = csel_sh ? ((xc >= `VIC_COL40_SET) && (xc < `VIC_COL40_CLR))
                         : ((xc >= `VIC_COL38_SET) && (xc < `VIC_COL38_CLR));
        in_row = rsel_sh ? ((rc >= `VIC_ROW25_SET) && (rc < `VIC_ROW25_CLR))
                         : ((rc >= `VIC_ROW24_SET) && (rc < `VIC_ROW24_CLR));
        if (hb || vb)
            c = '0;                          // Black in any blank
        else if (in_col && in_row && den_sh)
            c = bg_sh;
        else
            c = border_sh;
        return {xc[8:0], rc[8:0], c, hs ^ vs, hb || vb};
    endfunction

    task automatic write_reg(input logic [5:0] a, input vic_pkg::cpu_data_t d);
        @(negedge dot_clk);
        cs         = 1'b1;
        we         = 1'b1;
        addr       = a;
        wdata      = d;
        last_write = cycle;
        case (a)
            vic_pkg::CTRL1: begin
                den_sh  = d[4];
                rsel_sh = d[3];
            end
            vic_pkg::CTRL2:        csel_sh   = d[3];
            vic_pkg::BORDER_COLOR: border_sh = d[3:0];
            vic_pkg::BG0_COLOR:    bg_sh     = d[3:0];
            default:               ;
        endcase
        @(negedge dot_clk);
        cs = 1'b0;
        we = 1'b0;
    endtask

    // Data is picked up one clock after the read edge; at is the beam position there
    task automatic read_reg(input logic [5:0] a, output vic_pkg::cpu_data_t d, output longint at);
        @(negedge dot_clk);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        at   = cycle;
        @(negedge dot_clk);
        cs = 1'b0;
        d  = rdata;
    endtask

    task automatic compare_read(input logic [5:0] a, input vic_pkg::cpu_data_t got,
                                input vic_pkg::cpu_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: read of 0x%02h gave 0x%02h, expected 0x%02h",
                     $time, a, got, exp);
        end
    endtask

    task automatic check_read(input logic [5:0] a, input vic_pkg::cpu_data_t exp);
        vic_pkg::cpu_data_t d;
        longint             at;
        read_reg(a, d, at);
        compare_read(a, d, exp);
    endtask

    // Pre-edge samples; the outputs show the state after the previous edge
    always @(posedge dot_clk) begin : video_check
        logic [23:0] exp;
        if (reset) begin
            cycle     = 0;
            read_last = 1'b0;
        end else begin
            if (!read_last && rdata !== 8'h00) begin
                errors++;
                $display("ERROR at %0t: rdata 0x%02h on a clock without a read", $time, rdata);
            end
            if (cycle >= 3 && cycle - last_write > 4) begin   // Settled config only
                exp = raster_model(cycle - `VIC_VIDEO_LATENCY);
                checks++;
                if ({color, sync, blank} !== exp[5:0]) begin
                    errors++;
                    $display("ERROR at %0t: dot %0d line %0d color %0d sync %b blank %b, %s",
                             $time, exp[23:15], exp[14:6], color, sync, blank,
                             $sformatf("expected %0d %b %b", exp[5:2], exp[1], exp[0]));
                end
            end
            read_last = cs && !we;
            cycle     = cycle + 1;
        end
    end

    initial begin : stimulus
        vic_pkg::cpu_data_t d;
        vic_pkg::cpu_data_t r;
        vic_pkg::cpu_data_t g;
        longint             at;
        longint             t0;
        logic [23:0]        m;
        logic [8:0]         line;
        int                 combo;
        cs         = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        reset      = 1'b1;
        cycle      = 0;
        last_write = 0;
        errors     = 0;
        checks     = 0;
        read_last  = 1'b0;
        lcg_state  = 32'd51702;
        den_sh     = 1'b0;
        rsel_sh    = 1'b0;
        csel_sh    = 1'b0;
        border_sh  = '0;
        bg_sh      = '0;
        repeat (8) @(negedge dot_clk);
        reset = 1'b0;

        // Reset state
        checks++;
        if (irq !== 1'b0 || color !== 4'h0 || sync !== 1'b0 || blank !== 1'b0) begin
            errors++;
            $display("ERROR at %0t: outputs not zero after reset", $time);
        end
        check_read(vic_pkg::CTRL1, 8'h00);
        read_reg(vic_pkg::RASTER, d, at);
        m = raster_model(at);
        compare_read(vic_pkg::RASTER, d, m[13:6]);
        check_read(vic_pkg::CTRL2, 8'hC0);
        check_read(vic_pkg::IRQ_STATUS, 8'h7F);   // Compare line 0 already passed at dot 0
        check_read(vic_pkg::IRQ_ENABLE, 8'hFE);
        check_read(vic_pkg::BORDER_COLOR, 8'hF0);
        check_read(vic_pkg::BG0_COLOR, 8'hF0);

        // Register round trip with fixed bits
        r = lcg_next();
        write_reg(vic_pkg::CTRL1, r);
        read_reg(vic_pkg::CTRL1, d, at);
        m = raster_model(at);
        compare_read(vic_pkg::CTRL1, d, {m[14], r[6:0]});   // Bit 7 is beam line bit 8
        r = lcg_next();
        write_reg(vic_pkg::CTRL2, r);
        check_read(vic_pkg::CTRL2, {2'b11, r[5:0]});
        r = lcg_next();
        write_reg(vic_pkg::IRQ_ENABLE, r);
        check_read(vic_pkg::IRQ_ENABLE, {7'h7F, r[0]});
        r = lcg_next();
        write_reg(vic_pkg::BORDER_COLOR, r);
        check_read(vic_pkg::BORDER_COLOR, {4'hF, r[3:0]});
        r = lcg_next();
        write_reg(vic_pkg::BG0_COLOR, r);
        check_read(vic_pkg::BG0_COLOR, {4'hF, r[3:0]});
        read_reg(vic_pkg::RASTER, d, at);
        m = raster_model(at);
        compare_read(vic_pkg::RASTER, d, m[13:6]);
        check_read(6'h00, 8'hFF);                 // Unimplemented
        check_read(6'h13, 8'hFF);
        check_read(6'h3F, 8'hFF);

        // One frame of border, background, sync and blank per csel/rsel pair
        for (combo = 0; combo < 4; combo++) begin
            r = lcg_next();
            g = lcg_next();
            while (g[3:0] == r[3:0])
                g = lcg_next();                   // Border and background differ
            write_reg(vic_pkg::CTRL2, {4'b0000, combo[0], 3'b000});
            write_reg(vic_pkg::CTRL1, {3'b000, 1'b1, combo[1], 3'b000});   // DEN before line 48
            write_reg(vic_pkg::BORDER_COLOR, {4'h0, r[3:0]});
            write_reg(vic_pkg::BG0_COLOR, {4'h0, g[3:0]});
            repeat (300 * `VIC_DOTS_PER_LINE) @(negedge dot_clk);
            read_reg(vic_pkg::RASTER, d, at);     // Late line with beam bit 8 set
            m = raster_model(at);
            compare_read(vic_pkg::RASTER, d, m[13:6]);
            read_reg(vic_pkg::CTRL1, d, at);
            m = raster_model(at);
            compare_read(vic_pkg::CTRL1, d, {m[14], 2'b00, 1'b1, combo[1], 3'b000});
            repeat (FRAME - 300 * `VIC_DOTS_PER_LINE - 4) @(negedge dot_clk);
        end

        // Raster interrupt on an LCG line
        r    = lcg_next();
        g    = lcg_next();
        line = 9'({r, g} % `VIC_LINES_PER_FRAME);
        write_reg(vic_pkg::RASTER, line[7:0]);
        write_reg(vic_pkg::CTRL1, {line[8], 2'b00, 1'b1, rsel_sh, 3'b000});
        write_reg(vic_pkg::IRQ_ENABLE, 8'h01);
        write_reg(vic_pkg::IRQ_STATUS, 8'h01);    // Drop earlier hits
        checks++;
        if (irq !== 1'b0) begin
            errors++;
            $display("ERROR at %0t: irq still high after the status clear", $time);
        end
        t0 = cycle;
        while (irq !== 1'b1 && cycle - t0 < 2 * FRAME)
            @(negedge dot_clk);
        checks++;
        if (irq !== 1'b1) begin
            errors++;
            $display("The raster interrupt never rose within two frames for line %0d", line);
        end else begin
            m = raster_model(cycle - 1);          // Position at the setting edge
            if (m[23:15] !== 9'd0 || m[14:6] !== line) begin
                errors++;
                $display("ERROR at %0t: irq rose after dot %0d line %0d, expected dot 0 line %0d",
                         $time, m[23:15], m[14:6], line);
            end
        end
        repeat (2 * `VIC_DOTS_PER_LINE) begin
            @(negedge dot_clk);
            if (irq !== 1'b1) begin
                errors++;
                $display("ERROR at %0t: irq dropped before the clear", $time);
            end
        end
        check_read(vic_pkg::IRQ_STATUS, 8'hFF);   // Both irq and the latch set
        write_reg(vic_pkg::IRQ_STATUS, 8'h01);
        checks++;
        if (irq !== 1'b0) begin
            errors++;
            $display("ERROR at %0t: irq still high after write 1 to clear", $time);
        end
        check_read(vic_pkg::IRQ_STATUS, 8'h7E);
        write_reg(vic_pkg::IRQ_ENABLE, 8'h00);
        repeat (FRAME) begin                      // Passes the compare line once
            @(negedge dot_clk);
            if (irq !== 1'b0) begin
                errors++;
                $display("ERROR at %0t: irq high with the enable cleared", $time);
            end
        end
        check_read(vic_pkg::IRQ_STATUS, 8'h7F);   // Latch set, irq masked

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule
